// ==== sim.f ====
src/cdc_ctrl_pkg.sv
src/frame_parser.sv
src/cmd_dispatch.sv
src/pwm_bank.sv
src/reply_framer.sv
src/cdc_ctrl_top.sv
dv/cdc_ctrl_tb.sv

// ==== dv/cdc_ctrl_tb.sv ====
`timescale 1ns/1ps

module cdc_ctrl_tb;

    localparam int CLK_NS        = 100;
    localparam int RST_CYCLES    = 8;
    localparam int NUM_ROWS      = 24;
    localparam int BYTES_PER_ROW = 15;
    localparam int STALL_CYCLES  = 4;
    localparam int WATCHDOG_NS   = NUM_ROWS * BYTES_PER_ROW * STALL_CYCLES * CLK_NS
                                   + RST_CYCLES * CLK_NS;

    // request checksum handling per row
    localparam logic [1:0] SUM_GOOD = 2'd0;
    localparam logic [1:0] SUM_BAD  = 2'd1;
    localparam logic [1:0] SUM_NONE = 2'd2;
    // expected side effect per row
    localparam logic [1:0] FX_NONE  = 2'd0;
    localparam logic [1:0] FX_PWM   = 2'd1;
    localparam logic [1:0] FX_DAC   = 2'd2;

    localparam cdc_ctrl_pkg::dac_code_t HALF_SCALE = 14'h2000;

    // payload bytes are left aligned, first sent byte in [39:32]
    typedef struct packed {
        cdc_ctrl_pkg::byte_t cmd;
        cdc_ctrl_pkg::byte_t len;
        logic [39:0]         pay;
        logic [2:0]          npay;
        logic [1:0]          sum_mode;
        cdc_ctrl_pkg::byte_t exp_status;
        logic [15:0]         exp_data;
        logic [1:0]          effect;
    } row_t;

    logic                             clk;
    logic                             rst_n_i;
    cdc_ctrl_pkg::byte_t              in_data_i;
    logic                             in_valid_i;
    logic                             in_ready_o;
    cdc_ctrl_pkg::byte_t              out_data_o;
    logic                             out_valid_o;
    logic                             out_ready_i;
    logic [cdc_ctrl_pkg::NUM_PWM-1:0] pwm_o;
    cdc_ctrl_pkg::dac_code_t          dac_a_o;
    cdc_ctrl_pkg::dac_code_t          dac_b_o;

    integer                  seed = 32'h8c2b_55ec;
    row_t                    rows [NUM_ROWS];
    cdc_ctrl_pkg::byte_t     tx_q [$];
    cdc_ctrl_pkg::byte_t     rx_buf [6];
    cdc_ctrl_pkg::dac_code_t model_a;
    cdc_ctrl_pkg::dac_code_t model_b;

    cdc_ctrl_top dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .pwm_o       (pwm_o),
        .dac_a_o     (dac_a_o),
        .dac_b_o     (dac_b_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ==========================================================
    // failure reporting and compare tasks
    // ==========================================================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input cdc_ctrl_pkg::byte_t got,
                              input cdc_ctrl_pkg::byte_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_dac(input string name, input cdc_ctrl_pkg::dac_code_t got,
                             input cdc_ctrl_pkg::dac_code_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // high cycles over one full period, sampled mid-cycle
    task automatic check_duty(input cdc_ctrl_pkg::chan_t ch, input cdc_ctrl_pkg::pwm_cnt_t period,
                              input cdc_ctrl_pkg::pwm_cnt_t duty);
        cdc_ctrl_pkg::pwm_cnt_t highs;
        cdc_ctrl_pkg::pwm_cnt_t expect_highs;
        highs        = '0;
        expect_highs = (duty > period) ? period : duty;
        repeat (period) begin
            @(negedge clk);
            if (pwm_o[ch]) begin
                highs = highs + 16'd1;
            end
        end
        if (highs !== expect_highs) begin
            fail_run($sformatf("ERR pwm_o[%0d] high cycles got 0x%h expected 0x%h",
                               ch, highs, expect_highs));
        end
    endtask

    // ==========================================================
    // host side byte driver and reply collector
    // ==========================================================
    task automatic send_byte(input cdc_ctrl_pkg::byte_t b);
        int gap;
        gap = {$random(seed)} % 2;
        repeat (gap) begin
            @(negedge clk);
            in_valid_i = 1'b0;
        end
        @(negedge clk);
        in_valid_i = 1'b1;
        in_data_i  = b;
        #1;
        while (!in_ready_o) begin
            @(negedge clk);
            #1;
        end
        // transfer happens on this edge
        @(posedge clk);
    endtask

    task automatic send_frame();
        foreach (tx_q[i]) begin
            send_byte(tx_q[i]);
        end
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    task automatic collect_reply();
        int n;
        n = 0;
        while (n < 6) begin
            @(negedge clk);
            out_ready_i = ({$random(seed)} % 4) != 0;
            #1;
            if (out_valid_o && out_ready_i) begin
                rx_buf[n] = out_data_o;
                n++;
            end
        end
    endtask

    function automatic row_t make_row(input cdc_ctrl_pkg::byte_t cmd, input cdc_ctrl_pkg::byte_t len,
                                      input logic [39:0] pay, input logic [2:0] npay,
                                      input logic [1:0] sum_mode, input cdc_ctrl_pkg::byte_t st,
                                      input logic [15:0] data, input logic [1:0] effect);
        make_row = '{cmd, len, pay, npay, sum_mode, st, data, effect};
    endfunction

    task automatic load_table();
        rows[0]  = make_row(8'h01, 8'd5, 40'h02_000A_0003, 5, SUM_GOOD, 8'h00, 16'h0000, FX_PWM);
        rows[1]  = make_row(8'h01, 8'd5, 40'h05_0007_0007, 5, SUM_GOOD, 8'h00, 16'h0000, FX_PWM);
        rows[2]  = make_row(8'h01, 8'd5, 40'h00_000C_0000, 5, SUM_GOOD, 8'h00, 16'h0000, FX_PWM);
        rows[3]  = make_row(8'h03, 8'd1, 40'h02_0000_0000, 1, SUM_GOOD, 8'h00, 16'h000A, FX_NONE);
        rows[4]  = make_row(8'h03, 8'd1, 40'h12_0000_0000, 1, SUM_GOOD, 8'h00, 16'h0003, FX_NONE);
        rows[5]  = make_row(8'h03, 8'd1, 40'h05_0000_0000, 1, SUM_GOOD, 8'h00, 16'h0007, FX_NONE);
        rows[6]  = make_row(8'h03, 8'd1, 40'h15_0000_0000, 1, SUM_GOOD, 8'h00, 16'h0007, FX_NONE);
        // dac pair, A negative and B positive
        rows[7]  = make_row(8'h02, 8'd4, 40'h3ABC_C123_00, 4, SUM_GOOD, 8'h00, 16'h0000, FX_DAC);
        rows[8]  = make_row(8'h03, 8'd1, 40'h20_0000_0000, 1, SUM_GOOD, 8'h00, 16'hFABC, FX_NONE);
        rows[9]  = make_row(8'h03, 8'd1, 40'h21_0000_0000, 1, SUM_GOOD, 8'h00, 16'h0123, FX_NONE);
        // corrupted checksums must leave settings alone
        rows[10] = make_row(8'h02, 8'd4, 40'h0001_0002_00, 4, SUM_BAD,  8'h01, 16'h0000, FX_NONE);
        rows[11] = make_row(8'h03, 8'd1, 40'h20_0000_0000, 1, SUM_GOOD, 8'h00, 16'hFABC, FX_NONE);
        rows[12] = make_row(8'h01, 8'd5, 40'h02_0014_0005, 5, SUM_BAD,  8'h01, 16'h0000, FX_NONE);
        rows[13] = make_row(8'h03, 8'd1, 40'h02_0000_0000, 1, SUM_GOOD, 8'h00, 16'h000A, FX_NONE);
        // bad command cases
        rows[14] = make_row(8'h07, 8'd1, 40'h00_0000_0000, 1, SUM_GOOD, 8'h02, 16'h0000, FX_NONE);
        rows[15] = make_row(8'h01, 8'd4, 40'h02_0014_0000, 4, SUM_GOOD, 8'h02, 16'h0000, FX_NONE);
        rows[16] = make_row(8'h03, 8'd6, 40'h00_0000_0000, 0, SUM_NONE, 8'h02, 16'h0000, FX_NONE);
        rows[17] = make_row(8'h03, 8'd1, 40'h30_0000_0000, 1, SUM_GOOD, 8'h02, 16'h0000, FX_NONE);
        rows[18] = make_row(8'h03, 8'd1, 40'h08_0000_0000, 1, SUM_GOOD, 8'h02, 16'h0000, FX_NONE);
        rows[19] = make_row(8'h03, 8'd1, 40'h12_0000_0000, 1, SUM_GOOD, 8'h00, 16'h0003, FX_NONE);
        rows[20] = make_row(8'h02, 8'd4, 40'h1234_2000_00, 4, SUM_GOOD, 8'h00, 16'h0000, FX_DAC);
        rows[21] = make_row(8'h03, 8'd1, 40'h21_0000_0000, 1, SUM_GOOD, 8'h00, 16'hE000, FX_NONE);
        rows[22] = make_row(8'h03, 8'd1, 40'h20_0000_0000, 1, SUM_GOOD, 8'h00, 16'h1234, FX_NONE);
        rows[23] = make_row(8'h03, 8'd1, 40'h00_0000_0000, 1, SUM_GOOD, 8'h00, 16'h000C, FX_NONE);
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog timeout, the reply never arrived");
    end

    // ==========================================================
    // main sequence
    // ==========================================================
    initial begin
        row_t                cur;
        cdc_ctrl_pkg::byte_t req_sum;
        cdc_ctrl_pkg::byte_t exp_rx [6];

        rst_n_i     = 1'b0;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        model_a     = '0;
        model_b     = '0;
        load_table();

        repeat (RST_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;

        // idle state right after reset
        @(negedge clk);
        #1;
        check_byte("pwm_o", pwm_o, 8'h00);
        check_dac("dac_a_o", dac_a_o, HALF_SCALE);
        check_dac("dac_b_o", dac_b_o, HALF_SCALE);
        if (out_valid_o !== 1'b0) begin
            fail_run("out_valid_o is high right after reset");
        end
        if (in_ready_o !== 1'b1) begin
            fail_run("in_ready_o is low right after reset");
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            cur = rows[r];
            tx_q.delete();
            tx_q.push_back(8'hAA);
            tx_q.push_back(cur.cmd);
            tx_q.push_back(cur.len);
            req_sum = cur.cmd + cur.len;
            for (int k = 0; k < cur.npay; k++) begin
                tx_q.push_back(cur.pay[39 - 8 * k -: 8]);
                req_sum = req_sum + cur.pay[39 - 8 * k -: 8];
            end
            if (cur.sum_mode == SUM_GOOD) begin
                tx_q.push_back(req_sum);
            end else if (cur.sum_mode == SUM_BAD) begin
                tx_q.push_back(req_sum + 8'h01);
            end

            fork
                send_frame();
                collect_reply();
            join

            exp_rx[0] = 8'h55;
            exp_rx[1] = cur.cmd;
            exp_rx[2] = cur.exp_status;
            exp_rx[3] = cur.exp_data[15:8];
            exp_rx[4] = cur.exp_data[7:0];
            exp_rx[5] = exp_rx[1] + exp_rx[2] + exp_rx[3] + exp_rx[4];
            for (int i = 0; i < 6; i++) begin
                check_byte($sformatf("out_data_o row %0d byte %0d", r, i), rx_buf[i], exp_rx[i]);
            end

            // nothing may follow the checksum byte
            @(negedge clk);
            #1;
            if (out_valid_o !== 1'b0) begin
                fail_run($sformatf("extra reply byte after the checksum in row %0d", r));
            end

            if (cur.effect == FX_PWM) begin
                check_duty(cur.pay[34:32], cur.pay[31:16], cur.pay[15:0]);
            end else if (cur.effect == FX_DAC) begin
                model_a = cur.pay[37:24];
                model_b = cur.pay[21:8];
            end
            // offset binary is the signed code shifted by half scale
            check_dac("dac_a_o", dac_a_o, model_a + HALF_SCALE);
            check_dac("dac_b_o", dac_b_o, model_b + HALF_SCALE);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== src/cdc_ctrl_top.sv ====
`timescale 1ns/1ps

module cdc_ctrl_top (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  cdc_ctrl_pkg::byte_t              in_data_i,
    input  logic                             in_valid_i,
    output logic                             in_ready_o,
    output cdc_ctrl_pkg::byte_t              out_data_o,
    output logic                             out_valid_o,
    input  logic                             out_ready_i,
    output logic [cdc_ctrl_pkg::NUM_PWM-1:0] pwm_o,
    output cdc_ctrl_pkg::dac_code_t          dac_a_o,
    output cdc_ctrl_pkg::dac_code_t          dac_b_o
);

    cdc_ctrl_pkg::req_t     req;
    logic                   req_valid;
    logic                   req_ready;
    cdc_ctrl_pkg::rsp_t     rsp;
    logic                   rsp_valid;
    logic                   rsp_ready;
    logic                   pwm_wr;
    cdc_ctrl_pkg::pwm_cfg_t pwm_cfg;
    cdc_ctrl_pkg::chan_t    pwm_rd_chan;
    cdc_ctrl_pkg::pwm_cnt_t pwm_rd_period;
    cdc_ctrl_pkg::pwm_cnt_t pwm_rd_duty;

    // ==========================================================
    // request path
    // ==========================================================
    frame_parser u_frame_parser (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .req_o       (req),
        .req_valid_o (req_valid),
        .req_ready_i (req_ready)
    );

    cmd_dispatch u_cmd_dispatch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_i           (req),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .rsp_o           (rsp),
        .rsp_valid_o     (rsp_valid),
        .rsp_ready_i     (rsp_ready),
        .pwm_wr_o        (pwm_wr),
        .pwm_cfg_o       (pwm_cfg),
        .pwm_rd_chan_o   (pwm_rd_chan),
        .pwm_rd_period_i (pwm_rd_period),
        .pwm_rd_duty_i   (pwm_rd_duty),
        .dac_a_o         (dac_a_o),
        .dac_b_o         (dac_b_o)
    );

    pwm_bank u_pwm_bank (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wr_i        (pwm_wr),
        .cfg_i       (pwm_cfg),
        .rd_chan_i   (pwm_rd_chan),
        .rd_period_o (pwm_rd_period),
        .rd_duty_o   (pwm_rd_duty),
        .pwm_o       (pwm_o)
    );

    // reply path back to the host
    reply_framer u_reply_framer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rsp_i       (rsp),
        .rsp_valid_i (rsp_valid),
        .rsp_ready_o (rsp_ready),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== src/reply_framer.sv ====
`timescale 1ns/1ps

module reply_framer (
    input  logic                clk,
    input  logic                rst_n_i,
    input  cdc_ctrl_pkg::rsp_t  rsp_i,
    input  logic                rsp_valid_i,
    output logic                rsp_ready_o,
    output cdc_ctrl_pkg::byte_t out_data_o,
    output logic                out_valid_o,
    input  logic                out_ready_i
);

    cdc_ctrl_pkg::rsp_t  rsp_q;
    cdc_ctrl_pkg::byte_t sum_q;
    logic [2:0]          idx_q;
    logic                busy_q;
    logic                rsp_fire;
    logic                out_fire;
    logic                last_byte;

    assign rsp_ready_o = !busy_q;
    assign out_valid_o = busy_q;
    assign rsp_fire    = rsp_valid_i && rsp_ready_o;
    assign out_fire    = out_valid_o && out_ready_i;
    assign last_byte   = (idx_q == 3'(cdc_ctrl_pkg::RSP_LAST));

    // byte select, header first and checksum last
    always_comb begin
        case (idx_q)
            3'd0:    out_data_o = cdc_ctrl_pkg::RSP_HDR;
            3'd1:    out_data_o = rsp_q.cmd;
            3'd2:    out_data_o = rsp_q.status;
            3'd3:    out_data_o = rsp_q.data[15:8];
            3'd4:    out_data_o = rsp_q.data[7:0];
            default: out_data_o = sum_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (rsp_fire) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (out_fire) begin
            if (last_byte) begin
                busy_q <= 1'b0;
            end else begin
                idx_q <= idx_q + 3'd1;
            end
        end
    end

    // sum covers cmd, status and both data bytes
    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            rsp_q <= rsp_i;
            sum_q <= '0;
        end else if (out_fire && idx_q != 3'd0 && !last_byte) begin
            sum_q <= sum_q + out_data_o;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// ==== src/pwm_bank.sv ====
`timescale 1ns/1ps

module pwm_bank (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             wr_i,
    input  cdc_ctrl_pkg::pwm_cfg_t           cfg_i,
    input  cdc_ctrl_pkg::chan_t              rd_chan_i,
    output cdc_ctrl_pkg::pwm_cnt_t           rd_period_o,
    output cdc_ctrl_pkg::pwm_cnt_t           rd_duty_o,
    output logic [cdc_ctrl_pkg::NUM_PWM-1:0] pwm_o
);

    cdc_ctrl_pkg::pwm_cnt_t period_q [cdc_ctrl_pkg::NUM_PWM];
    cdc_ctrl_pkg::pwm_cnt_t duty_q   [cdc_ctrl_pkg::NUM_PWM];
    cdc_ctrl_pkg::pwm_cnt_t cnt_q    [cdc_ctrl_pkg::NUM_PWM];

    // combinational readback
    assign rd_period_o = period_q[rd_chan_i];
    assign rd_duty_o   = duty_q[rd_chan_i];

    // ==========================================================
    // one counter and comparator per channel
    // ==========================================================
    for (genvar i = 0; i < cdc_ctrl_pkg::NUM_PWM; i++) begin : g_chan
        logic sel;
        logic out_q;

        assign sel      = wr_i && (cfg_i.chan == cdc_ctrl_pkg::chan_t'(i));
        assign pwm_o[i] = out_q;

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                period_q[i] <= '0;
                duty_q[i]   <= '0;
                cnt_q[i]    <= '0;
                out_q       <= 1'b0;
            end else begin
                // new setting restarts the cycle
                if (sel) begin
                    period_q[i] <= cfg_i.period;
                    duty_q[i]   <= cfg_i.duty;
                    cnt_q[i]    <= '0;
                end else if (period_q[i] == '0) begin
                    cnt_q[i] <= '0;
                end else if (cnt_q[i] >= period_q[i] - 16'd1) begin
                    cnt_q[i] <= '0;
                end else begin
                    cnt_q[i] <= cnt_q[i] + 16'd1;
                end
                out_q <= (period_q[i] != '0) && (cnt_q[i] < duty_q[i]);
            end
        end

        a_zero_period_low: assert property (@(posedge clk) disable iff (!rst_n_i)
            period_q[i] == '0 |=> !pwm_o[i]);
    end

endmodule

// ==== src/cmd_dispatch.sv ====
`timescale 1ns/1ps

module cmd_dispatch (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  cdc_ctrl_pkg::req_t      req_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    output cdc_ctrl_pkg::rsp_t      rsp_o,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output logic                    pwm_wr_o,
    output cdc_ctrl_pkg::pwm_cfg_t  pwm_cfg_o,
    output cdc_ctrl_pkg::chan_t     pwm_rd_chan_o,
    input  cdc_ctrl_pkg::pwm_cnt_t  pwm_rd_period_i,
    input  cdc_ctrl_pkg::pwm_cnt_t  pwm_rd_duty_i,
    output cdc_ctrl_pkg::dac_code_t dac_a_o,
    output cdc_ctrl_pkg::dac_code_t dac_b_o
);

    cdc_ctrl_pkg::status_e   status;
    logic [15:0]             rd_data;
    logic                    pwm_hit;
    logic                    dac_hit;
    logic                    req_fire;
    cdc_ctrl_pkg::byte_t     rd_addr;
    cdc_ctrl_pkg::dac_code_t dac_a_q;
    cdc_ctrl_pkg::dac_code_t dac_b_q;
    cdc_ctrl_pkg::rsp_t      rsp_q;
    logic                    rsp_valid_q;

    assign req_ready_o   = !rsp_valid_q;
    assign req_fire      = req_valid_i && req_ready_o;
    assign rsp_o         = rsp_q;
    assign rsp_valid_o   = rsp_valid_q;
    assign rd_addr       = req_i.payload[7:0];
    assign pwm_rd_chan_o = rd_addr[2:0];
    assign pwm_wr_o      = req_fire && pwm_hit;
    // len 5 layout: chan, period hi/lo, duty hi/lo
    assign pwm_cfg_o     = '{chan:   req_i.payload[34:32],
                             period: req_i.payload[31:16],
                             duty:   req_i.payload[15:0]};

    // ==========================================================
    // decode and status
    // ==========================================================
    always_comb begin
        status  = cdc_ctrl_pkg::OK;
        rd_data = '0;
        pwm_hit = 1'b0;
        dac_hit = 1'b0;
        if (!req_i.sum_ok) begin
            status = cdc_ctrl_pkg::BAD_SUM;
        end else if (req_i.len_err) begin
            status = cdc_ctrl_pkg::BAD_CMD;
        end else begin
            case (req_i.cmd)
                cdc_ctrl_pkg::PWM_SET: begin
                    if (req_i.len == 8'd5) pwm_hit = 1'b1;
                    else status = cdc_ctrl_pkg::BAD_CMD;
                end
                cdc_ctrl_pkg::DAC_SET: begin
                    if (req_i.len == 8'd4) dac_hit = 1'b1;
                    else status = cdc_ctrl_pkg::BAD_CMD;
                end
                cdc_ctrl_pkg::READ: begin
                    if (req_i.len != 8'd1) begin
                        status = cdc_ctrl_pkg::BAD_CMD;
                    end else if (rd_addr[7:3] == 5'h00) begin
                        rd_data = pwm_rd_period_i;
                    end else if (rd_addr[7:3] == 5'h02) begin
                        rd_data = pwm_rd_duty_i;
                    end else if (rd_addr == 8'h20) begin
                        rd_data = {{2{dac_a_q[13]}}, dac_a_q};
                    end else if (rd_addr == 8'h21) begin
                        rd_data = {{2{dac_b_q[13]}}, dac_b_q};
                    end else begin
                        status = cdc_ctrl_pkg::BAD_CMD;
                    end
                end
                default: status = cdc_ctrl_pkg::BAD_CMD;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
            dac_a_q     <= '0;
            dac_b_q     <= '0;
            dac_a_o     <= cdc_ctrl_pkg::DAC_MID;
            dac_b_o     <= cdc_ctrl_pkg::DAC_MID;
        end else begin
            if (req_fire) begin
                rsp_valid_q <= 1'b1;
            end else if (rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
            // low 14 bits of each 16-bit pair
            if (req_fire && dac_hit) begin
                dac_a_q <= req_i.payload[29:16];
                dac_b_q <= req_i.payload[13:0];
            end
            // flip sign bit for offset binary
            dac_a_o <= {~dac_a_q[13], dac_a_q[12:0]};
            dac_b_o <= {~dac_b_q[13], dac_b_q[12:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_q <= '{cmd: req_i.cmd, status: status, data: rd_data};
        end
    end

    a_wr_only_ok: assert property (@(posedge clk) disable iff (!rst_n_i)
        pwm_wr_o |=> rsp_valid_o && rsp_o.status == cdc_ctrl_pkg::OK
                     && rsp_o.cmd == cdc_ctrl_pkg::PWM_SET);

endmodule

// ==== src/frame_parser.sv ====
`timescale 1ns/1ps

module frame_parser (
    input  logic                clk,
    input  logic                rst_n_i,
    input  cdc_ctrl_pkg::byte_t in_data_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    output cdc_ctrl_pkg::req_t  req_o,
    output logic                req_valid_o,
    input  logic                req_ready_i
);

    cdc_ctrl_pkg::parse_state_e state_q;
    cdc_ctrl_pkg::parse_state_e state_d;
    cdc_ctrl_pkg::req_t         req_q;
    cdc_ctrl_pkg::byte_t        sum_q;
    cdc_ctrl_pkg::byte_t        rem_q;
    logic                       in_fire;
    logic                       len_too_big;

    // stream is held off only while a request waits
    assign in_ready_o  = (state_q != cdc_ctrl_pkg::HOLD);
    assign req_valid_o = (state_q == cdc_ctrl_pkg::HOLD);
    assign req_o       = req_q;
    assign in_fire     = in_valid_i && in_ready_o;
    assign len_too_big = in_data_i > cdc_ctrl_pkg::byte_t'(cdc_ctrl_pkg::MAX_PAYLOAD);

    // ==========================================================
    // frame FSM
    // ==========================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            cdc_ctrl_pkg::HUNT: begin
                if (in_fire && in_data_i == cdc_ctrl_pkg::REQ_HDR) begin
                    state_d = cdc_ctrl_pkg::CMD;
                end
            end
            cdc_ctrl_pkg::CMD: begin
                if (in_fire) begin
                    state_d = cdc_ctrl_pkg::LEN;
                end
            end
            cdc_ctrl_pkg::LEN: begin
                if (in_fire) begin
                    // oversize length goes straight out, no payload or sum
                    if (len_too_big) begin
                        state_d = cdc_ctrl_pkg::HOLD;
                    end else if (in_data_i == 8'd0) begin
                        state_d = cdc_ctrl_pkg::SUM;
                    end else begin
                        state_d = cdc_ctrl_pkg::PAYLOAD;
                    end
                end
            end
            cdc_ctrl_pkg::PAYLOAD: begin
                if (in_fire && rem_q == 8'd1) begin
                    state_d = cdc_ctrl_pkg::SUM;
                end
            end
            cdc_ctrl_pkg::SUM: begin
                if (in_fire) begin
                    state_d = cdc_ctrl_pkg::HOLD;
                end
            end
            default: begin
                if (req_ready_i) begin
                    state_d = cdc_ctrl_pkg::HUNT;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= cdc_ctrl_pkg::HUNT;
        end else begin
            state_q <= state_d;
        end
    end

    // request fields and running sum
    always_ff @(posedge clk) begin
        if (in_fire) begin
            case (state_q)
                cdc_ctrl_pkg::CMD: begin
                    req_q.cmd <= in_data_i;
                    sum_q     <= in_data_i;
                end
                cdc_ctrl_pkg::LEN: begin
                    req_q.len     <= in_data_i;
                    req_q.payload <= '0;
                    req_q.len_err <= len_too_big;
                    // oversize frames are reported as BAD_CMD, not BAD_SUM
                    req_q.sum_ok  <= 1'b1;
                    sum_q         <= sum_q + in_data_i;
                    rem_q         <= in_data_i;
                end
                cdc_ctrl_pkg::PAYLOAD: begin
                    req_q.payload <= {req_q.payload[cdc_ctrl_pkg::PAY_W-9:0], in_data_i};
                    sum_q         <= sum_q + in_data_i;
                    rem_q         <= rem_q - 8'd1;
                end
                cdc_ctrl_pkg::SUM: begin
                    req_q.sum_ok <= (in_data_i == sum_q);
                end
                default: begin
                end
            endcase
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o));

endmodule

// ==== src/cdc_ctrl_pkg.sv ====
package cdc_ctrl_pkg;

    // ==========================================================
    // widths that carry a meaning
    // ==========================================================
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  chan_t;
    typedef logic [15:0] pwm_cnt_t;
    // two's complement in dispatch, offset binary at the pins
    typedef logic [13:0] dac_code_t;

    localparam byte_t       REQ_HDR     = 8'hAA;
    localparam byte_t       RSP_HDR     = 8'h55;
    localparam int unsigned MAX_PAYLOAD = 5;
    localparam int unsigned PAY_W       = MAX_PAYLOAD * 8;
    localparam int unsigned NUM_PWM     = 8;
    // index of the checksum byte in a reply
    localparam int unsigned RSP_LAST    = 5;
    localparam dac_code_t   DAC_MID     = 14'h2000;

    typedef enum logic [7:0] {
        PWM_SET = 8'h01,
        DAC_SET = 8'h02,
        READ    = 8'h03
    } cmd_e;

    typedef enum logic [7:0] {
        OK      = 8'h00,
        BAD_SUM = 8'h01,
        BAD_CMD = 8'h02
    } status_e;

    typedef enum logic [2:0] {
        HUNT,
        CMD,
        LEN,
        PAYLOAD,
        SUM,
        HOLD
    } parse_state_e;

    // ==========================================================
    // frame structs
    // ==========================================================
    // payload is right aligned, first received byte is the highest one
    typedef struct packed {
        byte_t              cmd;
        byte_t              len;
        logic [PAY_W-1:0]   payload;
        logic               sum_ok;
        logic               len_err;
    } req_t;

    typedef struct packed {
        byte_t       cmd;
        status_e     status;
        logic [15:0] data;
    } rsp_t;

    typedef struct packed {
        chan_t    chan;
        pwm_cnt_t period;
        pwm_cnt_t duty;
    } pwm_cfg_t;

endpackage
